// File: common/mac_pre_pkg.sv
// element widths, datatype enumeration and beat structs
// shared by the mac pre-processing unit
package mac_pre_pkg;

    ////////////////////
    // sizes
    ////////////////////

    // elements per beat
    localparam int ELEMS = 4;
    // raw element as it arrives on the ports
    localparam int RAW_W = 16;
    // decoded element as seen by the mac lanes
    localparam int DEC_W = 20;

    ////////////////////
    // datatype
    ////////////////////

    typedef enum logic {
        DTYPE_FP16 = 1'b0,
        DTYPE_INT8 = 1'b1
    } dtype_e;

    // decoded element layout, msb first
    //   fp16: 2'b00, iszero, sign, exp5, mant11
    //         iszero when exponent and fraction are both zero
    //         mant11 is hidden bit then fraction, hidden set for nonzero exponent
    //   int8: high byte in [19:10], low byte in [9:0]
    //         each byte is iszero, sign, 8-bit magnitude
    //         magnitude is the absolute value, so -128 gives 128

    ////////////////////
    // lines and beats
    ////////////////////

    // element 0 in the low bits
    typedef logic [ELEMS-1:0][RAW_W-1:0] raw_line_t;
    typedef logic [ELEMS-1:0][DEC_W-1:0] dec_line_t;

    typedef struct packed {
        raw_line_t        data;
        logic [ELEMS-1:0] elem_valid;
        logic             inter_end;
        logic             accum_end;
    } ifm_beat_t;

    typedef struct packed {
        raw_line_t data;
        logic      is_last;
    } wfm_beat_t;

    // decoded ifm beat towards the lanes
    typedef struct packed {
        dec_line_t        data;
        logic [ELEMS-1:0] elem_valid;
        logic             inter_end;
        logic             accum_end;
    } lane_ifm_t;

endpackage

// File: hdl/element_decoder.sv
// combinational fp16 / int8 decode of one raw line
`timescale 1ns/1ps

module element_decoder (
    input  mac_pre_pkg::dtype_e    i_dtype,
    input  mac_pre_pkg::raw_line_t i_data,
    output mac_pre_pkg::dec_line_t o_data
);

    import mac_pre_pkg::*;

    ////////////////////
    // fp16
    ////////////////////

    function automatic logic [DEC_W-1:0] decode_fp16(input logic [RAW_W-1:0] raw);
        logic [4:0] exp5;
        logic [9:0] frac;
        logic       iszero;
        logic       hidden;
        exp5   = raw[14:10];
        frac   = raw[9:0];
        iszero = (exp5 == 5'd0) && (frac == 10'd0);
        // zero exponent keeps the hidden bit clear
        hidden = (exp5 != 5'd0);
        return {2'b00, iszero, raw[15], exp5, hidden, frac};
    endfunction

    ////////////////////
    // int8
    ////////////////////

    function automatic logic [9:0] decode_byte(input logic [7:0] b);
        logic [7:0] mag;
        // two's complement abs, 8'h80 stays 128
        mag = b[7] ? (~b + 8'd1) : b;
        return {b == 8'd0, b[7], mag};
    endfunction

    function automatic logic [DEC_W-1:0] decode_int8(input logic [RAW_W-1:0] raw);
        return {decode_byte(raw[15:8]), decode_byte(raw[7:0])};
    endfunction

    for (genvar e = 0; e < ELEMS; e++) begin : g_elem
        assign o_data[e] = (i_dtype == DTYPE_FP16) ? decode_fp16(i_data[e])
                                                   : decode_int8(i_data[e]);
    end

endmodule

// File: hdl/ifm_pipe.sv
// ifm register pipeline with element-gated capture
// and inter/accum flag transport
`timescale 1ns/1ps

module ifm_pipe #(
    parameter int STAGES = 2
) (
    input  logic                              i_clk,
    input  logic                              i_reset,
    output logic                              o_input_ready,
    input  logic                              i_input_valid,
    input  mac_pre_pkg::dec_line_t            i_data,
    input  logic [mac_pre_pkg::ELEMS-1:0]     i_elem_valid,
    input  logic                              i_inter_end,
    input  logic                              i_accum_end,
    input  logic                              i_output_ready,
    output logic                              o_output_valid,
    output mac_pre_pkg::lane_ifm_t            o_lane
);

    import mac_pre_pkg::*;

    logic [STAGES-1:0] stage_en;

    dec_line_t         r_data [STAGES];
    logic [ELEMS-1:0]  r_elem_valid [STAGES];
    logic [STAGES-1:0] r_inter_end;
    logic [STAGES-1:0] r_accum_end;

    // stage inputs, stage 0 from the fifo side
    dec_line_t         src_data [STAGES];
    logic [ELEMS-1:0]  src_elem_valid [STAGES];
    logic [STAGES-1:0] src_inter_end;
    logic [STAGES-1:0] src_accum_end;

    pipe_ctrl #(
        .STAGE (STAGES)
    ) u_pipe_ctrl (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_input_ready  (o_input_ready),
        .i_input_valid  (i_input_valid),
        .i_output_ready (i_output_ready),
        .o_output_valid (o_output_valid),
        .o_pipe_ctrl    (stage_en)
    );

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        if (k == 0) begin : g_src_in
            assign src_data[k]       = i_data;
            assign src_elem_valid[k] = i_elem_valid;
            assign src_inter_end[k]  = i_inter_end;
            assign src_accum_end[k]  = i_accum_end;
        end else begin : g_src_prev
            assign src_data[k]       = r_data[k-1];
            assign src_elem_valid[k] = r_elem_valid[k-1];
            assign src_inter_end[k]  = r_inter_end[k-1];
            assign src_accum_end[k]  = r_accum_end[k-1];
        end

        always_ff @(posedge i_clk or negedge i_reset) begin
            if (!i_reset) begin
                r_elem_valid[k] <= '0;
                r_inter_end[k]  <= 1'b0;
                r_accum_end[k]  <= 1'b0;
            end else if (stage_en[k]) begin
                r_elem_valid[k] <= src_elem_valid[k];
                r_inter_end[k]  <= src_inter_end[k];
                r_accum_end[k]  <= src_accum_end[k];
            end
        end

        // invalid elements keep stale contents
        always_ff @(posedge i_clk) begin
            for (int e = 0; e < ELEMS; e++) begin
                if (stage_en[k] && src_elem_valid[k][e]) begin
                    r_data[k][e] <= src_data[k][e];
                end
            end
        end
    end

    assign o_lane.data       = r_data[STAGES-1];
    assign o_lane.elem_valid = r_elem_valid[STAGES-1];
    assign o_lane.inter_end  = r_inter_end[STAGES-1];
    assign o_lane.accum_end  = r_accum_end[STAGES-1];

endmodule

// File: hdl/mac_pre_processing_unit.sv
// mac pre-processing top: stream fifos, decoders,
// ifm pipe and weight frame buffer
`timescale 1ns/1ps

module mac_pre_processing_unit #(
    parameter int FIFO_DEPTH = 4,
    parameter int IFM_STAGES = 2,
    parameter int BUF_LINES  = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  mac_pre_pkg::dtype_e                    i_ifm_dtype,
    input  mac_pre_pkg::dtype_e                    i_wfm_dtype,
    output logic                                   o_ifm_ready,
    input  logic                                   i_ifm_valid,
    input  mac_pre_pkg::ifm_beat_t                 i_ifm,
    output logic                                   o_wfm_ready,
    input  logic                                   i_wfm_valid,
    input  mac_pre_pkg::wfm_beat_t                 i_wfm,
    input  logic                                   i_lane_ifm_ready,
    output logic                                   o_lane_ifm_valid,
    output mac_pre_pkg::lane_ifm_t                 o_lane_ifm,
    output logic [BUF_LINES-1:0]                   o_lane_wfm_valid,
    output mac_pre_pkg::dec_line_t [BUF_LINES-1:0] o_lane_wfm
);

    import mac_pre_pkg::*;

    logic      ifm_fifo_valid;
    logic      ifm_fifo_ready;
    ifm_beat_t ifm_fifo_data;
    dec_line_t ifm_dec;

    logic      wfm_fifo_valid;
    logic      wfm_fifo_ready;
    wfm_beat_t wfm_fifo_data;
    dec_line_t wfm_dec;

    logic      frame_pop;

    ////////////////////
    // ifm path
    ////////////////////

    stream_fifo #(
        .DATA_T (ifm_beat_t),
        .DEPTH  (FIFO_DEPTH)
    ) u_ifm_fifo (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_input_ready  (o_ifm_ready),
        .i_input_valid  (i_ifm_valid),
        .i_input_data   (i_ifm),
        .i_output_ready (ifm_fifo_ready),
        .o_output_valid (ifm_fifo_valid),
        .o_output_data  (ifm_fifo_data)
    );

    element_decoder u_ifm_decoder (
        .i_dtype (i_ifm_dtype),
        .i_data  (ifm_fifo_data.data),
        .o_data  (ifm_dec)
    );

    ifm_pipe #(
        .STAGES (IFM_STAGES)
    ) u_ifm_pipe (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_input_ready  (ifm_fifo_ready),
        .i_input_valid  (ifm_fifo_valid),
        .i_data         (ifm_dec),
        .i_elem_valid   (ifm_fifo_data.elem_valid),
        .i_inter_end    (ifm_fifo_data.inter_end),
        .i_accum_end    (ifm_fifo_data.accum_end),
        .i_output_ready (i_lane_ifm_ready),
        .o_output_valid (o_lane_ifm_valid),
        .o_lane         (o_lane_ifm)
    );

    ////////////////////
    // weight path
    ////////////////////

    stream_fifo #(
        .DATA_T (wfm_beat_t),
        .DEPTH  (FIFO_DEPTH)
    ) u_wfm_fifo (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_input_ready  (o_wfm_ready),
        .i_input_valid  (i_wfm_valid),
        .i_input_data   (i_wfm),
        .i_output_ready (wfm_fifo_ready),
        .o_output_valid (wfm_fifo_valid),
        .o_output_data  (wfm_fifo_data)
    );

    element_decoder u_wfm_decoder (
        .i_dtype (i_wfm_dtype),
        .i_data  (wfm_fifo_data.data),
        .o_data  (wfm_dec)
    );

    // frame leaves once the lanes take an inner-loop end
    assign frame_pop = o_lane_ifm_valid & i_lane_ifm_ready & o_lane_ifm.inter_end;

    weight_frame_buffer #(
        .BUF_LINES (BUF_LINES)
    ) u_weight_frame_buffer (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .o_input_ready (wfm_fifo_ready),
        .i_input_valid (wfm_fifo_valid),
        .i_data        (wfm_dec),
        .i_is_last     (wfm_fifo_data.is_last),
        .i_frame_pop   (frame_pop),
        .o_line_valid  (o_lane_wfm_valid),
        .o_lines       (o_lane_wfm)
    );

endmodule

// File: hdl/pipe_ctrl.sv
// stage-valid tracker with per-stage load enables
`timescale 1ns/1ps

module pipe_ctrl #(
    parameter int STAGE = 2
) (
    input  logic             i_clk,
    input  logic             i_reset,
    output logic             o_input_ready,
    input  logic             i_input_valid,
    input  logic             i_output_ready,
    output logic             o_output_valid,
    output logic [STAGE-1:0] o_pipe_ctrl
);

    logic [STAGE-1:0] r_valid;
    // bit k: stage k can take an item this cycle
    logic [STAGE:0]   ready_chain;
    logic [STAGE:0]   valid_chain;

    // a stage is ready when empty or its item moves on
    always_comb begin
        ready_chain[STAGE] = i_output_ready;
        for (int k = STAGE - 1; k >= 0; k--) begin
            ready_chain[k] = !r_valid[k] | ready_chain[k+1];
        end
    end

    assign valid_chain    = {r_valid, i_input_valid};
    assign o_pipe_ctrl    = valid_chain[STAGE-1:0] & ready_chain[STAGE-1:0];
    assign o_input_ready  = ready_chain[0];
    assign o_output_valid = r_valid[STAGE-1];

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            r_valid <= '0;
        end else begin
            r_valid <= o_pipe_ctrl | (r_valid & ~ready_chain[STAGE:1]);
        end
    end

    // stalled item is neither overwritten nor lost
    for (genvar k = 0; k < STAGE; k++) begin : g_stall_chk
        a_no_load_stalled : assert property (@(posedge i_clk) disable iff (!i_reset)
            r_valid[k] && !ready_chain[k+1] |-> !o_pipe_ctrl[k] ##1 r_valid[k]);
    end

endmodule

// File: hdl/stream_fifo.sv
// ready/valid fifo with a type-parameter payload
`timescale 1ns/1ps

module stream_fifo #(
    parameter type DATA_T = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  i_clk,
    input  logic  i_reset,
    output logic  o_input_ready,
    input  logic  i_input_valid,
    input  DATA_T i_input_data,
    input  logic  i_output_ready,
    output logic  o_output_valid,
    output DATA_T o_output_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_T            mem [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_input_ready  = (r_count != CNT_W'(DEPTH));
    assign o_output_valid = (r_count != '0);
    assign o_output_data  = mem[r_rd_ptr];

    assign push = i_input_valid & o_input_ready;
    assign pop  = o_output_valid & i_output_ready;

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (push) begin
                r_wr_ptr <= next_ptr(r_wr_ptr);
            end
            if (pop) begin
                r_rd_ptr <= next_ptr(r_rd_ptr);
            end
            r_count <= r_count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[r_wr_ptr] <= i_input_data;
        end
    end

    // full fifo with no read stays full and takes nothing
    a_no_write_full : assert property (@(posedge i_clk) disable iff (!i_reset)
        (r_count == CNT_W'(DEPTH)) && !pop |-> !push ##1 (r_count == CNT_W'(DEPTH)));

    a_count_range : assert property (@(posedge i_clk) disable iff (!i_reset)
        r_count <= CNT_W'(DEPTH));

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, and pass only on the pass message
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_mac_pre -o tb_mac_pre \
    && ./obj_dir/tb_mac_pre | tee /dev/stderr | grep -q "^test passed$" \
    || exit 1

// File: src.f
+incdir+tb
common/mac_pre_pkg.sv
hdl/stream_fifo.sv
hdl/pipe_ctrl.sv
hdl/element_decoder.sv
hdl/ifm_pipe.sv
weight_buffer/weight_frame_buffer.sv
hdl/mac_pre_processing_unit.sv
tb/tb_mac_pre.sv

// File: tb/tb_mac_pre_ref.svh
// reference decode for fp16 and int8 elements
// and helpers for expected lane beats and weight frames
`ifndef TB_MAC_PRE_REF_SVH
`define TB_MAC_PRE_REF_SVH

////////////////////
// element decode
////////////////////

// msb first: 2'b00, iszero, sign, exp5, hidden, fraction
function automatic logic [DEC_W-1:0] ref_decode_fp16(input logic [RAW_W-1:0] raw);
    logic [DEC_W-1:0] d;
    logic             exp_nonzero;
    exp_nonzero = |raw[14:10];
    d           = '0;
    d[17]       = !exp_nonzero && (raw[9:0] == 10'd0);
    d[16]       = raw[15];
    d[15:11]    = raw[14:10];
    d[10]       = exp_nonzero;
    d[9:0]      = raw[9:0];
    return d;
endfunction

// iszero, sign, magnitude of one signed byte
function automatic logic [9:0] int8_byte_fields(input logic [7:0] b);
    int         value;
    logic [9:0] f;
    value = int'($signed(b));
    if (value < 0) begin
        value = -value;
    end
    f[9]   = (value == 0);
    f[8]   = b[7];
    f[7:0] = value[7:0];
    return f;
endfunction

function automatic logic [DEC_W-1:0] ref_decode_int8(input logic [RAW_W-1:0] raw);
    logic [DEC_W-1:0] d;
    d[19:10] = int8_byte_fields(raw[15:8]);
    d[9:0]   = int8_byte_fields(raw[7:0]);
    return d;
endfunction

function automatic dec_line_t ref_decode_line(input dtype_e dt, input raw_line_t raw);
    dec_line_t line;
    for (int e = 0; e < ELEMS; e++) begin
        if (dt == DTYPE_FP16) begin
            line[e] = ref_decode_fp16(raw[e]);
        end else begin
            line[e] = ref_decode_int8(raw[e]);
        end
    end
    return line;
endfunction

////////////////////
// expected outputs
////////////////////

function automatic lane_ifm_t expected_lane(input dtype_e dt, input ifm_beat_t beat);
    lane_ifm_t lane;
    lane.data       = ref_decode_line(dt, beat.data);
    lane.elem_valid = beat.elem_valid;
    lane.inter_end  = beat.inter_end;
    lane.accum_end  = beat.accum_end;
    return lane;
endfunction

// lines 0 up to len-1 are shown
function automatic logic [BUF_LINES-1:0] frame_line_mask(input int len);
    logic [BUF_LINES-1:0] mask;
    for (int k = 0; k < BUF_LINES; k++) begin
        mask[k] = (k < len);
    end
    return mask;
endfunction

`endif

// File: tb/tb_mac_pre.sv
// testbench for the mac pre-processing unit: stimulus, scoreboards,
// output comparison, timeout and summary
`timescale 1ns/1ps

module tb_mac_pre;

    import mac_pre_pkg::*;

    localparam int BUF_LINES  = 8;
    localparam int N_RAND_IFM = 40;
    localparam int N_FRAMES   = 6;
    // two mixed phases with release beats, then four frames under back-pressure
    localparam int PHASE_BEATS = N_RAND_IFM + 2 + N_FRAMES * (BUF_LINES + 4);
    localparam int TOTAL_BEATS = 2 * PHASE_BEATS + 4 * (BUF_LINES + 4);
    localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

    typedef dec_line_t [BUF_LINES-1:0] frame_t;

    `include "tb_mac_pre_ref.svh"

    logic                 i_clk;
    logic                 i_reset;
    dtype_e               i_ifm_dtype;
    dtype_e               i_wfm_dtype;
    logic                 o_ifm_ready;
    logic                 i_ifm_valid;
    ifm_beat_t            i_ifm;
    logic                 o_wfm_ready;
    logic                 i_wfm_valid;
    wfm_beat_t            i_wfm;
    logic                 i_lane_ifm_ready;
    logic                 o_lane_ifm_valid;
    lane_ifm_t            o_lane_ifm;
    logic [BUF_LINES-1:0] o_lane_wfm_valid;
    frame_t               o_lane_wfm;

    lane_ifm_t exp_ifm [$];
    frame_t    exp_frames [$];
    int        exp_lens [$];
    int        errors;
    int        ifm_checked;
    int        frames_released;
    int        cycles;
    logic      wfm_done;

    mac_pre_processing_unit #(
        .FIFO_DEPTH (4),
        .IFM_STAGES (2),
        .BUF_LINES  (BUF_LINES)
    ) DUT (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_ifm_dtype      (i_ifm_dtype),
        .i_wfm_dtype      (i_wfm_dtype),
        .o_ifm_ready      (o_ifm_ready),
        .i_ifm_valid      (i_ifm_valid),
        .i_ifm            (i_ifm),
        .o_wfm_ready      (o_wfm_ready),
        .i_wfm_valid      (i_wfm_valid),
        .i_wfm            (i_wfm),
        .i_lane_ifm_ready (i_lane_ifm_ready),
        .o_lane_ifm_valid (o_lane_ifm_valid),
        .o_lane_ifm       (o_lane_ifm),
        .o_lane_wfm_valid (o_lane_wfm_valid),
        .o_lane_wfm       (o_lane_wfm)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    // zeros, signs, zero exponent, inf, -128 and 127
    function automatic raw_line_t directed_line(input dtype_e dt, input int idx);
        if (dt == DTYPE_FP16) begin
            return (idx == 0) ? {16'hC500, 16'h03FF, 16'h8000, 16'h0000}
                              : {16'h7C00, 16'h7BFF, 16'h3C00, 16'h0001};
        end
        return (idx == 0) ? {16'h7F80, 16'hFF00, 16'h807F, 16'h00FF}
                          : {16'h0180, 16'hFE7F, 16'h0000, 16'h8080};
    endfunction

    function automatic raw_line_t random_raw_line();
        return {$urandom(), $urandom()};
    endfunction

    function automatic ifm_beat_t random_ifm_beat();
        ifm_beat_t b;
        b.data       = random_raw_line();
        b.elem_valid = ELEMS'($urandom());
        b.inter_end  = ($urandom() % 4) == 0;
        b.accum_end  = ($urandom() % 3) == 0;
        return b;
    endfunction

    // called at 2 ns after a rising edge, returns at the same point
    task automatic send_ifm(input ifm_beat_t beat);
        logic accepted;
        exp_ifm.push_back(expected_lane(i_ifm_dtype, beat));
        i_ifm       = beat;
        i_ifm_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge i_clk);
            accepted = o_ifm_ready;
            @(posedge i_clk);
            #2;
        end
        i_ifm_valid = 1'b0;
    endtask

    task automatic send_frame(input int len, input logic directed);
        raw_line_t lines [BUF_LINES];
        frame_t    frame;
        wfm_beat_t beat;
        logic      accepted;
        frame = '0;
        for (int j = 0; j < len; j++) begin
            if (directed && j < 2) begin
                lines[j] = directed_line(i_wfm_dtype, j);
            end else begin
                lines[j] = random_raw_line();
            end
            frame[j] = ref_decode_line(i_wfm_dtype, lines[j]);
        end
        exp_frames.push_back(frame);
        exp_lens.push_back(len);
        for (int j = 0; j < len; j++) begin
            beat.data    = lines[j];
            beat.is_last = (j == len - 1);
            i_wfm        = beat;
            i_wfm_valid  = 1'b1;
            accepted     = 1'b0;
            while (!accepted) begin
                @(negedge i_clk);
                accepted = o_wfm_ready;
                @(posedge i_clk);
                #2;
            end
        end
        i_wfm_valid = 1'b0;
    endtask

    // inter-end beats until every frame has left
    task automatic release_frames();
        ifm_beat_t beat;
        while (!wfm_done || exp_frames.size() != 0) begin
            beat           = random_ifm_beat();
            beat.inter_end = 1'b1;
            send_ifm(beat);
        end
    endtask

    task automatic wait_ifm_drained();
        while (exp_ifm.size() != 0) begin
            @(posedge i_clk);
            #2;
        end
    endtask

    task automatic run_mixed_phase(input dtype_e ifm_dt, input dtype_e wfm_dt);
        ifm_beat_t beat;
        i_ifm_dtype = ifm_dt;
        i_wfm_dtype = wfm_dt;
        wfm_done    = 1'b0;
        fork
            begin
                for (int i = 0; i < 2; i++) begin
                    beat            = '0;
                    beat.data       = directed_line(ifm_dt, i);
                    beat.elem_valid = '1;
                    send_ifm(beat);
                end
                for (int i = 0; i < N_RAND_IFM; i++) begin
                    send_ifm(random_ifm_beat());
                end
                release_frames();
            end
            begin
                send_frame(BUF_LINES, 1'b1);
                for (int f = 1; f < N_FRAMES; f++) begin
                    send_frame(1 + $urandom_range(BUF_LINES - 1), 1'b0);
                end
                wfm_done = 1'b1;
            end
        join
        wait_ifm_drained();
    endtask

    task automatic run_backpressure_phase();
        int waited;
        i_wfm_dtype = DTYPE_INT8;
        wfm_done    = 1'b0;
        fork
            begin
                for (int f = 0; f < 3; f++) begin
                    send_frame(1 + $urandom_range(2), 1'b0);
                end
                // lines behind the stalled frames fill the fifo
                send_frame(BUF_LINES, 1'b0);
                wfm_done = 1'b1;
            end
            begin
                waited = 0;
                @(negedge i_clk);
                while (o_wfm_ready && waited < 40 * BUF_LINES) begin
                    @(negedge i_clk);
                    waited++;
                end
                if (o_wfm_ready) begin
                    errors++;
                    $display("o_wfm_ready stayed high while the frame buffer was full");
                end
                repeat (4) @(posedge i_clk);
                #2;
                release_frames();
            end
        join
        wait_ifm_drained();
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int seed;
        seed             = $urandom(32'hb7a4);
        errors           = 0;
        ifm_checked      = 0;
        frames_released  = 0;
        i_reset          = 1'b0;
        i_ifm_dtype      = DTYPE_FP16;
        i_wfm_dtype      = DTYPE_INT8;
        i_ifm_valid      = 1'b0;
        i_ifm            = '0;
        i_wfm_valid      = 1'b0;
        i_wfm            = '0;
        i_lane_ifm_ready = 1'b0;
        wfm_done         = 1'b0;
        repeat (8) @(posedge i_clk);
        #2;
        i_reset = 1'b1;
        @(negedge i_clk);
        if (o_lane_ifm_valid !== 1'b0) report_mismatch("o_lane_ifm_valid", o_lane_ifm_valid, 0);
        if (o_lane_wfm_valid !== '0) report_mismatch("o_lane_wfm_valid", o_lane_wfm_valid, 0);
        if (o_ifm_ready !== 1'b1) report_mismatch("o_ifm_ready", o_ifm_ready, 1);
        if (o_wfm_ready !== 1'b1) report_mismatch("o_wfm_ready", o_wfm_ready, 1);
        @(posedge i_clk);
        #2;

        run_mixed_phase(DTYPE_FP16, DTYPE_INT8);
        run_mixed_phase(DTYPE_INT8, DTYPE_FP16);
        run_backpressure_phase();
        repeat (4) @(posedge i_clk);

        if (ifm_checked == 0 || frames_released == 0) begin
            errors++;
            $display("no ifm beat or weight frame reached the output");
        end
        $display("errors: %0d  ifm beats checked: %0d  frames released: %0d",
                 errors, ifm_checked, frames_released);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // random lane back-pressure
    initial begin
        i_lane_ifm_ready = 1'b0;
        forever begin
            @(posedge i_clk);
            #2;
            i_lane_ifm_ready = i_reset && (($urandom() % 4) != 0);
        end
    end

    ////////////////////
    // output comparison
    ////////////////////

    initial begin
        lane_ifm_t exp_lane;
        logic      pop_frame;
        forever begin
            @(negedge i_clk);
            pop_frame = 1'b0;
            if (i_reset && o_lane_ifm_valid && i_lane_ifm_ready) begin
                if (exp_ifm.size() == 0) begin
                    errors++;
                    $display("ifm beat at %0t with no beat expected", $time);
                end else begin
                    exp_lane = exp_ifm.pop_front();
                    ifm_checked++;
                    // an inner-loop end taken by the lanes releases the shown frame
                    pop_frame = exp_lane.inter_end;
                    if (o_lane_ifm.elem_valid !== exp_lane.elem_valid)
                        report_mismatch("o_lane_ifm.elem_valid", o_lane_ifm.elem_valid,
                                        exp_lane.elem_valid);
                    if (o_lane_ifm.inter_end !== exp_lane.inter_end)
                        report_mismatch("o_lane_ifm.inter_end", o_lane_ifm.inter_end,
                                        exp_lane.inter_end);
                    if (o_lane_ifm.accum_end !== exp_lane.accum_end)
                        report_mismatch("o_lane_ifm.accum_end", o_lane_ifm.accum_end,
                                        exp_lane.accum_end);
                    for (int e = 0; e < ELEMS; e++) begin
                        if (exp_lane.elem_valid[e] && o_lane_ifm.data[e] !== exp_lane.data[e])
                            report_mismatch($sformatf("o_lane_ifm.data[%0d]", e),
                                            o_lane_ifm.data[e], exp_lane.data[e]);
                    end
                end
            end
            // a held frame must match the head until it is released
            if (i_reset && o_lane_wfm_valid != '0) begin
                if (exp_frames.size() == 0) begin
                    errors++;
                    $display("weight frame shown at %0t with no frame expected", $time);
                end else begin
                    if (o_lane_wfm_valid !== frame_line_mask(exp_lens[0]))
                        report_mismatch("o_lane_wfm_valid", o_lane_wfm_valid,
                                        frame_line_mask(exp_lens[0]));
                    for (int j = 0; j < exp_lens[0]; j++) begin
                        if (o_lane_wfm[j] !== exp_frames[0][j])
                            report_mismatch($sformatf("o_lane_wfm[%0d]", j),
                                            o_lane_wfm[j], exp_frames[0][j]);
                    end
                    if (pop_frame) begin
                        void'(exp_frames.pop_front());
                        void'(exp_lens.pop_front());
                        frames_released++;
                    end
                end
            end
        end
    end

    ////////////////////
    // timeout
    ////////////////////

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
        $display("test failed");
        $finish;
    end

endmodule

// File: weight_buffer/weight_frame_buffer.sv
// weight decode register, line collection into a fill bank
// and a two-entry frame pipe released by inter-end pops
`timescale 1ns/1ps

module weight_frame_buffer #(
    parameter int BUF_LINES = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    output logic                                   o_input_ready,
    input  logic                                   i_input_valid,
    input  mac_pre_pkg::dec_line_t                 i_data,
    input  logic                                   i_is_last,
    input  logic                                   i_frame_pop,
    output logic [BUF_LINES-1:0]                   o_line_valid,
    output mac_pre_pkg::dec_line_t [BUF_LINES-1:0] o_lines
);

    import mac_pre_pkg::*;

    // one extra bit so an overlong frame is visible
    localparam int PTR_W = $clog2(BUF_LINES + 1);
    localparam int IDX_W = (BUF_LINES > 1) ? $clog2(BUF_LINES) : 1;

    logic [0:0]       dec_en;
    logic             dec_valid;
    logic             dec_out_ready;
    dec_line_t        r_dec_line;
    logic             r_dec_last;

    logic             frm_in_valid;
    logic             frm_in_ready;
    logic             frm_valid;
    logic [1:0]       frm_en;

    logic             line_wr;
    logic [PTR_W-1:0] r_ptr;
    dec_line_t        fill_bank [BUF_LINES];
    dec_line_t [BUF_LINES-1:0] commit_frame;
    dec_line_t [BUF_LINES-1:0] r_frame [2];
    logic [PTR_W-1:0] r_last_idx [2];

    ////////////////////
    // decode register
    ////////////////////

    pipe_ctrl #(
        .STAGE (1)
    ) u_pipe_ctrl_dec (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_input_ready  (o_input_ready),
        .i_input_valid  (i_input_valid),
        .i_output_ready (dec_out_ready),
        .o_output_valid (dec_valid),
        .o_pipe_ctrl    (dec_en)
    );

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            r_dec_last <= 1'b0;
        end else if (dec_en[0]) begin
            r_dec_last <= i_is_last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (dec_en[0]) begin
            r_dec_line <= i_data;
        end
    end

    ////////////////////
    // line collection
    ////////////////////

    // only the closing line waits for frame room
    assign dec_out_ready = r_dec_last ? frm_in_ready : 1'b1;
    assign line_wr       = dec_valid & dec_out_ready;
    assign frm_in_valid  = dec_valid & r_dec_last;

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            r_ptr <= '0;
        end else if (line_wr) begin
            r_ptr <= r_dec_last ? '0 : r_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (line_wr) begin
            fill_bank[r_ptr[IDX_W-1:0]] <= r_dec_line;
        end
    end

    // closing line merged in, it is not yet in the fill bank
    always_comb begin
        for (int j = 0; j < BUF_LINES; j++) begin
            commit_frame[j] = (PTR_W'(j) == r_ptr) ? r_dec_line : fill_bank[j];
        end
    end

    ////////////////////
    // frame pipe
    ////////////////////

    pipe_ctrl #(
        .STAGE (2)
    ) u_pipe_ctrl_frame (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_input_ready  (frm_in_ready),
        .i_input_valid  (frm_in_valid),
        .i_output_ready (i_frame_pop),
        .o_output_valid (frm_valid),
        .o_pipe_ctrl    (frm_en)
    );

    always_ff @(posedge i_clk) begin
        if (frm_en[0]) begin
            r_frame[0]    <= commit_frame;
            r_last_idx[0] <= r_ptr;
        end
        if (frm_en[1]) begin
            r_frame[1]    <= r_frame[0];
            r_last_idx[1] <= r_last_idx[0];
        end
    end

    assign o_lines = r_frame[1];

    for (genvar k = 0; k < BUF_LINES; k++) begin : g_line_valid
        assign o_line_valid[k] = frm_valid && (PTR_W'(k) <= r_last_idx[1]);
    end

    // frames longer than BUF_LINES lines
    a_ptr_range : assert property (@(posedge i_clk) disable iff (!i_reset)
        r_ptr < PTR_W'(BUF_LINES));

endmodule
